// ==== include/bgpu_params.svh ====
/*
 * Size constants of the GPU front end, shared by the pipeline package and the RTL.
 * Include this file before a module or package that needs one of the sizes.
 */
`ifndef BGPU_PARAMS_SVH
`define BGPU_PARAMS_SVH

// Program counter bits
`define BGPU_PC_WIDTH 16
// Warps per compute unit
`define BGPU_NUM_WARPS 4
// Threads per warp, also the active mask width
`define BGPU_WARP_WIDTH 8
// Program memory words
`define BGPU_IMEM_DEPTH 256
// Entries of the dispatch queue
`define BGPU_QUEUE_DEPTH 4

`endif

// ==== logic/bgpu_isa_pkg.sv ====
/*
 * Instruction set encodings: execution units, subtypes, the opcode byte and
 * the two views of a 32-bit instruction word.
 */
package bgpu_isa_pkg;

    // Execution unit, upper nibble of the opcode
    typedef enum logic [3:0] {
        EU_IU  = 4'd0,
        EU_LSU = 4'd1,
        EU_BRU = 4'd2
    } eu_e;

    // Integer unit operations, register forms first
    typedef enum logic [3:0] {
        IU_ADD  = 4'd0,
        IU_SUB  = 4'd1,
        IU_AND  = 4'd2,
        IU_OR   = 4'd3,
        IU_XOR  = 4'd4,
        IU_SHL  = 4'd5,
        IU_ADDI = 4'd8,
        IU_SUBI = 4'd9,
        IU_SHLI = 4'd10
    } iu_subtype_e;

    typedef enum logic [3:0] {
        BRU_JMP    = 4'd0,
        BRU_SYNC   = 4'd1,
        BRU_BRANCH = 4'd2
    } bru_subtype_e;

    typedef struct packed {
        eu_e        eu;
        logic [3:0] subtype;
    } inst_t;

    // All ones in the opcode byte halts the warp
    localparam logic [7:0] OPCODE_STOP = 8'hFF;

    typedef struct packed {
        inst_t      opcode;
        logic [7:0] dst;
        logic [7:0] op0;
        logic [7:0] op1;
    } reg_form_t;

    // Jump view, the low half is a signed PC offset
    typedef struct packed {
        inst_t              opcode;
        logic [7:0]         dst;
        logic signed [15:0] offset;
    } imm_form_t;

    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } enc_inst_u;

endpackage

// ==== logic/bgpu_pipe_pkg.sv ====
/*
 * Payload types carried between the front end stages: fetch request,
 * fetch response, decoded instruction and decoder feedback to the fetcher.
 */
`include "bgpu_params.svh"

package bgpu_pipe_pkg;
    import bgpu_isa_pkg::*;

    typedef logic [$clog2(`BGPU_NUM_WARPS)-1:0] wid_t;
    typedef logic [`BGPU_PC_WIDTH-1:0]          pc_t;
    typedef logic [`BGPU_WARP_WIDTH-1:0]        act_mask_t;
    typedef logic [7:0]                         reg_idx_t;

    typedef struct packed {
        pc_t       pc;
        wid_t      warp_id;
        act_mask_t act_mask;
    } fetch_req_t;

    // Request echoed back together with the word read from memory
    typedef struct packed {
        fetch_req_t req;
        enc_inst_u  inst;
    } fetch_rsp_t;

    typedef struct packed {
        pc_t                 pc;
        wid_t                warp_id;
        act_mask_t           act_mask;
        inst_t               inst;
        reg_idx_t            dst;
        reg_idx_t [1:0]      operands;
        logic     [1:0]      operands_required;
    } dec_inst_t;

    // Next PC report, valid while decoded is high
    typedef struct packed {
        logic decoded;
        wid_t warp_id;
        logic stop;
        logic branch;
        pc_t  next_pc;
    } dec_fb_t;

endpackage

// ==== logic/warp_fetcher.sv ====
/*
 * Warp table and fetch issue. Holds PC, mask and state per warp and sends one
 * fetch request per cycle for a runnable warp chosen round-robin.
 */
`timescale 1ns/1ns
`include "bgpu_params.svh"

module warp_fetcher (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             launch_i,
    input  bgpu_pipe_pkg::wid_t              launch_warp_id_i,
    input  bgpu_pipe_pkg::pc_t               launch_pc_i,
    input  bgpu_pipe_pkg::act_mask_t         launch_act_mask_i,
    input  bgpu_pipe_pkg::dec_fb_t           fb_i,
    output logic                             req_valid_o,
    input  logic                             req_ready_i,
    output bgpu_pipe_pkg::fetch_req_t        req_o,
    output logic [`BGPU_NUM_WARPS-1:0]       warps_idle_o
);
    import bgpu_pipe_pkg::*;

    localparam int unsigned NUM_WARPS = `BGPU_NUM_WARPS;

    pc_t                  pc_q       [NUM_WARPS];
    act_mask_t            act_mask_q [NUM_WARPS];
    logic [NUM_WARPS-1:0] running_q;
    logic [NUM_WARPS-1:0] inflight_q;
    wid_t                 rr_q;
    logic                 req_valid_q;
    fetch_req_t           req_q;
    logic                 slot_free;
    logic                 sel_found;
    wid_t                 sel_wid;
    logic                 issue;

    // Output register is free once its request has been taken
    assign slot_free = !req_valid_q || req_ready_i;
    assign issue     = slot_free && sel_found;

    always_comb begin : pick_warp
        wid_t cand;
        sel_found = 1'b0;
        sel_wid   = rr_q;
        cand      = rr_q;
        for (int unsigned i = 0; i < NUM_WARPS; i++) begin
            cand = wid_t'((rr_q + i) % NUM_WARPS);
            if (!sel_found && running_q[cand] && !inflight_q[cand]) begin
                sel_found = 1'b1;
                sel_wid   = cand;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : ctrl_regs
        if (!rst_n_i) begin
            running_q   <= '0;
            inflight_q  <= '0;
            rr_q        <= '0;
            req_valid_q <= 1'b0;
        end else begin
            if (slot_free) begin
                req_valid_q <= sel_found;
            end
            if (issue) begin
                inflight_q[sel_wid] <= 1'b1;
                rr_q                <= wid_t'((sel_wid + 1) % NUM_WARPS);
            end
            // Selected warp is never the one reporting back
            if (fb_i.decoded) begin
                inflight_q[fb_i.warp_id] <= 1'b0;
                if (fb_i.stop) begin
                    running_q[fb_i.warp_id] <= 1'b0;
                end
            end
            if (launch_i) begin
                running_q[launch_warp_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        if (issue) begin
            req_q.pc       <= pc_q[sel_wid];
            req_q.warp_id  <= sel_wid;
            req_q.act_mask <= act_mask_q[sel_wid];
        end
        if (fb_i.decoded) begin
            pc_q[fb_i.warp_id] <= fb_i.next_pc;
        end
        if (launch_i) begin
            pc_q[launch_warp_id_i]       <= launch_pc_i;
            act_mask_q[launch_warp_id_i] <= launch_act_mask_i;
        end
    end

    assign req_valid_o  = req_valid_q;
    assign req_o        = req_q;
    assign warps_idle_o = ~running_q;

    fb_only_inflight: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fb_i.decoded |-> inflight_q[fb_i.warp_id]);

    launch_only_stopped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        launch_i |-> !running_q[launch_warp_id_i]);

    // Branches are resolved later, so fetch falls through
    branch_falls_through: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fb_i.decoded && fb_i.branch |-> fb_i.next_pc == pc_q[fb_i.warp_id] + pc_t'(1));

endmodule

// ==== logic/inst_memory.sv ====
/*
 * Program RAM with a test-load write port. A fetch request reads one word
 * into an output register that holds while the decoder is not ready.
 */
`timescale 1ns/1ns
`include "bgpu_params.svh"

module inst_memory (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      prog_we_i,
    input  bgpu_pipe_pkg::pc_t        prog_addr_i,
    input  bgpu_isa_pkg::enc_inst_u   prog_data_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  bgpu_pipe_pkg::fetch_req_t req_i,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    output bgpu_pipe_pkg::fetch_rsp_t rsp_o
);
    import bgpu_isa_pkg::*;
    import bgpu_pipe_pkg::*;

    localparam int unsigned DEPTH  = `BGPU_IMEM_DEPTH;
    localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    enc_inst_u  mem_q [DEPTH];
    logic       rsp_valid_q;
    fetch_rsp_t rsp_q;
    logic       req_hs;

    // Take a new request when the output slot empties this cycle
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign req_hs      = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin : write_port
        if (prog_we_i) begin
            mem_q[prog_addr_i[ADDR_W-1:0]] <= prog_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : rsp_valid_reg
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_ready_o) begin
            rsp_valid_q <= req_valid_i;
        end
    end

    // Read data and request tag are captured together
    always_ff @(posedge clk_i) begin : rsp_data_reg
        if (req_hs) begin
            rsp_q.req  <= req_i;
            rsp_q.inst <= mem_q[req_i.pc[ADDR_W-1:0]];
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

// ==== logic/decoder.sv ====
/*
 * Combinational instruction decoder between program memory and dispatch queue.
 * Splits the word into fields, works out the next PC for the fetcher and keeps
 * stop, jump and sync out of the dispatch path.
 */
`timescale 1ns/1ns

module decoder (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // From program memory
    output logic                      dec_ready_o,
    input  logic                      ic_valid_i,
    input  bgpu_pipe_pkg::fetch_rsp_t ic_rsp_i,
    // To dispatch queue
    input  logic                      disp_ready_i,
    output logic                      dec_valid_o,
    output bgpu_pipe_pkg::dec_inst_t  dec_inst_o,
    // Back to the fetcher
    output bgpu_pipe_pkg::dec_fb_t    dec_fb_o
);
    import bgpu_isa_pkg::*;
    import bgpu_pipe_pkg::*;

    inst_t      opcode;
    logic       is_stop;
    logic       is_control;
    logic       is_branch;
    logic [1:0] op_req;
    pc_t        next_pc;

    assign opcode  = ic_rsp_i.inst.reg_form.opcode;
    assign is_stop = opcode == OPCODE_STOP;

    assign dec_ready_o = disp_ready_i;
    assign dec_valid_o = ic_valid_i && !is_control;

    // Fields go out unchanged, only the flags are decoded
    assign dec_inst_o.pc                = ic_rsp_i.req.pc;
    assign dec_inst_o.warp_id           = ic_rsp_i.req.warp_id;
    assign dec_inst_o.act_mask          = ic_rsp_i.req.act_mask;
    assign dec_inst_o.inst              = opcode;
    assign dec_inst_o.dst               = ic_rsp_i.inst.reg_form.dst;
    assign dec_inst_o.operands[0]       = ic_rsp_i.inst.reg_form.op0;
    assign dec_inst_o.operands[1]       = ic_rsp_i.inst.reg_form.op1;
    assign dec_inst_o.operands_required = op_req;

    // Leaves the decoder when taken as control or accepted by the queue
    assign dec_fb_o.decoded = ((ic_valid_i && is_control) || dec_valid_o) && disp_ready_i;
    assign dec_fb_o.warp_id = ic_rsp_i.req.warp_id;
    assign dec_fb_o.stop    = is_stop;
    assign dec_fb_o.branch  = is_branch;
    assign dec_fb_o.next_pc = next_pc;

    always_comb begin : decode
        next_pc    = ic_rsp_i.req.pc + pc_t'(1);
        is_branch  = 1'b0;
        is_control = is_stop;
        // Bit 1 is operand 1, bit 0 is operand 0
        op_req     = 2'b00;

        if (opcode.eu == EU_IU) begin
            if (opcode.subtype inside {IU_ADD, IU_SUB, IU_AND, IU_OR, IU_XOR, IU_SHL}) begin
                op_req = 2'b11;
            end else if (opcode.subtype inside {IU_ADDI, IU_SUBI, IU_SHLI}) begin
                // Operand 0 carries the immediate
                op_req = 2'b10;
            end
        end else if (opcode.eu == EU_LSU) begin
            // Address and store data both come from registers
            op_req = 2'b11;
        end else if (opcode.eu == EU_BRU) begin
            case (opcode.subtype)
                BRU_JMP: begin
                    next_pc    = ic_rsp_i.req.pc
                               + pc_t'(ic_rsp_i.inst.imm_form.offset) + pc_t'(1);
                    is_control = 1'b1;
                end
                BRU_SYNC: begin
                    // Barrier lives in the back end, here it just advances
                    is_control = 1'b1;
                end
                BRU_BRANCH: begin
                    // Condition register in operand 1, offset immediate in operand 0
                    op_req    = 2'b10;
                    is_branch = 1'b1;
                end
                default: begin
                    op_req = 2'b00;
                end
            endcase
        end
    end

    // Program memory keeps its word while the queue stalls
    rsp_held_on_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ic_valid_i && !dec_ready_o |=> ic_valid_i && $stable(ic_rsp_i));

endmodule

// ==== logic/dispatch_queue.sv ====
/*
 * Circular FIFO between decoder and dispatcher. Entries appear at the output
 * one cycle after they are written; ready drops while the queue is full.
 */
`timescale 1ns/1ns
`include "bgpu_params.svh"

module dispatch_queue (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  bgpu_pipe_pkg::dec_inst_t in_i,
    output logic                     disp_valid_o,
    input  logic                     disp_ready_i,
    output bgpu_pipe_pkg::dec_inst_t disp_inst_o
);
    import bgpu_pipe_pkg::*;

    localparam int unsigned DEPTH = `BGPU_QUEUE_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dec_inst_t        fifo_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign in_ready_o   = count_q != (PTR_W + 1)'(DEPTH);
    assign disp_valid_o = count_q != '0;
    assign disp_inst_o  = fifo_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = disp_valid_o && disp_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : ptr_regs
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin : storage
        if (push) begin
            fifo_q[wr_ptr_q] <= in_i;
        end
    end

    // Full queue has both pointers on its oldest entry
    full_ptrs_meet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_q == (PTR_W + 1)'(DEPTH) |-> wr_ptr_q == rd_ptr_q);

endmodule

// ==== logic/bgpu_frontend.sv ====
/*
 * GPU instruction front end. Chains warp fetcher, program memory, decoder and
 * dispatch queue; decoded non-control instructions leave through disp_*.
 */
`timescale 1ns/1ns
`include "bgpu_params.svh"

module bgpu_frontend (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Warp launch
    input  logic                       launch_i,
    input  bgpu_pipe_pkg::wid_t        launch_warp_id_i,
    input  bgpu_pipe_pkg::pc_t         launch_pc_i,
    input  bgpu_pipe_pkg::act_mask_t   launch_act_mask_i,
    // Program load, only while all warps are idle
    input  logic                       prog_we_i,
    input  bgpu_pipe_pkg::pc_t         prog_addr_i,
    input  bgpu_isa_pkg::enc_inst_u    prog_data_i,
    // Towards the dispatcher
    output logic                       disp_valid_o,
    input  logic                       disp_ready_i,
    output bgpu_pipe_pkg::dec_inst_t   disp_inst_o,
    output logic [`BGPU_NUM_WARPS-1:0] warps_idle_o
);
    import bgpu_pipe_pkg::*;

    logic       fetch_valid;
    logic       fetch_ready;
    fetch_req_t fetch_req;
    logic       rsp_valid;
    logic       rsp_ready;
    fetch_rsp_t rsp;
    logic       dec_valid;
    logic       queue_ready;
    dec_inst_t  dec_inst;
    dec_fb_t    dec_fb;

    warp_fetcher i_fetcher (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .launch_i          (launch_i),
        .launch_warp_id_i  (launch_warp_id_i),
        .launch_pc_i       (launch_pc_i),
        .launch_act_mask_i (launch_act_mask_i),
        .fb_i              (dec_fb),
        .req_valid_o       (fetch_valid),
        .req_ready_i       (fetch_ready),
        .req_o             (fetch_req),
        .warps_idle_o      (warps_idle_o)
    );

    inst_memory i_imem (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .prog_we_i   (prog_we_i),
        .prog_addr_i (prog_addr_i),
        .prog_data_i (prog_data_i),
        .req_valid_i (fetch_valid),
        .req_ready_o (fetch_ready),
        .req_i       (fetch_req),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    decoder i_decoder (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .dec_ready_o  (rsp_ready),
        .ic_valid_i   (rsp_valid),
        .ic_rsp_i     (rsp),
        .disp_ready_i (queue_ready),
        .dec_valid_o  (dec_valid),
        .dec_inst_o   (dec_inst),
        .dec_fb_o     (dec_fb)
    );

    dispatch_queue i_queue (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_valid_i   (dec_valid),
        .in_ready_o   (queue_ready),
        .in_i         (dec_inst),
        .disp_valid_o (disp_valid_o),
        .disp_ready_i (disp_ready_i),
        .disp_inst_o  (disp_inst_o)
    );

endmodule

// ==== tests/tb_bgpu_frontend.sv ====
/*
 * Directed testbench for the GPU front end. Each test loads a program, launches
 * warps and compares the dispatched instructions per warp with the expected stream.
 */
`timescale 1ns/1ns
`include "bgpu_params.svh"

module tb_bgpu_frontend;
    import bgpu_isa_pkg::*;
    import bgpu_pipe_pkg::*;

    localparam int NUM_WARPS       = `BGPU_NUM_WARPS;
    localparam int NUM_TESTS       = 5;
    // Longest test program and a generous bound on cycles per word
    localparam int MAX_WORDS       = 16;
    localparam int CYCLES_PER_WORD = 18;
    localparam int DRAIN_CYCLES    = MAX_WORDS * CYCLES_PER_WORD;
    // Two load cycles per word plus the drain bound and some slack per test
    localparam int TIMEOUT_CYCLES  = 8 + NUM_TESTS * (MAX_WORDS * 2 + DRAIN_CYCLES + 16);

    logic                 clk_i = 1'b0;
    logic                 rst_n_i;
    logic                 launch_i;
    wid_t                 launch_warp_id_i;
    pc_t                  launch_pc_i;
    act_mask_t            launch_act_mask_i;
    logic                 prog_we_i;
    pc_t                  prog_addr_i;
    enc_inst_u            prog_data_i;
    logic                 disp_valid_o;
    logic                 disp_ready_i;
    dec_inst_t            disp_inst_o;
    logic [NUM_WARPS-1:0] warps_idle_o;

    dec_inst_t  exp_q[$];
    dec_inst_t  got_q[$];
    pc_t        load_pc;
    wid_t       cur_wid;
    act_mask_t  cur_mask;
    logic       random_ready = 1'b0;
    logic [7:0] lfsr_q = 8'd12;
    int         cycle_cnt = 0;
    int         checks = 0;
    int         errors = 0;
    int         checks_at_start;
    int         errors_at_start;

    bgpu_frontend uut (.*);

    always #50 clk_i = ~clk_i;

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    always @(posedge clk_i) begin : ready_driver
        if (random_ready) begin
            lfsr_q = lfsr_next(lfsr_q);
            disp_ready_i <= lfsr_q[0];
        end else begin
            disp_ready_i <= 1'b1;
        end
    end

    always @(posedge clk_i) begin : dispatch_monitor
        if (rst_n_i && disp_valid_o && disp_ready_i) begin
            got_q.push_back(disp_inst_o);
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_inst(input dec_inst_t got, input dec_inst_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: warp %0d pc %h dispatched %h, expected %h",
                     $time, exp.warp_id, exp.pc, got, exp);
        end
    endtask

    task automatic check_idle(input logic [NUM_WARPS-1:0] got,
                              input logic [NUM_WARPS-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s, warps_idle_o %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic enc_inst_u reg_word(input inst_t op, input reg_idx_t dst,
                                           input reg_idx_t op0, input reg_idx_t op1);
        enc_inst_u w;
        w.reg_form.opcode = op;
        w.reg_form.dst    = dst;
        w.reg_form.op0    = op0;
        w.reg_form.op1    = op1;
        return w;
    endfunction

    task automatic load_word(input pc_t addr, input enc_inst_u word);
        @(posedge clk_i);
        prog_we_i   <= 1'b1;
        prog_addr_i <= addr;
        prog_data_i <= word;
        @(posedge clk_i);
        prog_we_i   <= 1'b0;
    endtask

    task automatic start_program(input wid_t w, input act_mask_t m, input pc_t base);
        cur_wid  = w;
        cur_mask = m;
        load_pc  = base;
    endtask

    // Instruction that must reach the dispatcher
    task automatic prog_op(input eu_e eu, input logic [3:0] sub, input reg_idx_t dst,
                           input reg_idx_t op0, input reg_idx_t op1, input logic [1:0] req);
        inst_t     op;
        dec_inst_t e;
        op.eu                = eu;
        op.subtype           = sub;
        e.pc                 = load_pc;
        e.warp_id            = cur_wid;
        e.act_mask           = cur_mask;
        e.inst               = op;
        e.dst                = dst;
        e.operands[0]        = op0;
        e.operands[1]        = op1;
        e.operands_required  = req;
        exp_q.push_back(e);
        load_word(load_pc, reg_word(op, dst, op0, op1));
        load_pc = load_pc + pc_t'(1);
    endtask

    task automatic prog_word(input enc_inst_u w);
        load_word(load_pc, w);
        load_pc = load_pc + pc_t'(1);
    endtask

    task automatic prog_sync();
        inst_t op;
        op.eu      = EU_BRU;
        op.subtype = BRU_SYNC;
        prog_word(reg_word(op, 8'd0, 8'd0, 8'd0));
    endtask

    task automatic prog_stop();
        enc_inst_u w;
        w = 32'hFF00_0000;
        prog_word(w);
    endtask

    // Program continues at the jump target
    task automatic prog_jump(input logic signed [15:0] off);
        enc_inst_u w;
        w.imm_form.opcode.eu      = EU_BRU;
        w.imm_form.opcode.subtype = BRU_JMP;
        w.imm_form.dst            = 8'd0;
        w.imm_form.offset         = off;
        load_word(load_pc, w);
        load_pc = load_pc + pc_t'(off) + pc_t'(1);
    endtask

    task automatic launch_warp(input wid_t w, input pc_t pc, input act_mask_t m);
        @(posedge clk_i);
        launch_i          <= 1'b1;
        launch_warp_id_i  <= w;
        launch_pc_i       <= pc;
        launch_act_mask_i <= m;
        @(posedge clk_i);
        launch_i          <= 1'b0;
    endtask

    // Wait for stopped warps and an empty queue within the drain bound
    task automatic wait_drained();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!(&warps_idle_o && !disp_valid_o) && waited < DRAIN_CYCLES);
        repeat (4) @(posedge clk_i);
    endtask

    task automatic check_streams();
        dec_inst_t got_w[$];
        dec_inst_t exp_w[$];
        for (int w = 0; w < NUM_WARPS; w++) begin
            got_w.delete();
            exp_w.delete();
            foreach (got_q[i]) begin
                if (got_q[i].warp_id == wid_t'(w)) begin
                    got_w.push_back(got_q[i]);
                end
            end
            foreach (exp_q[i]) begin
                if (exp_q[i].warp_id == wid_t'(w)) begin
                    exp_w.push_back(exp_q[i]);
                end
            end
            if (got_w.size() != exp_w.size()) begin
                errors++;
                $display("error at %0t: warp %0d dispatched %0d instructions, expected %0d",
                         $time, w, got_w.size(), exp_w.size());
            end
            for (int i = 0; i < exp_w.size() && i < got_w.size(); i++) begin
                check_inst(got_w[i], exp_w[i]);
            end
        end
        check_idle(warps_idle_o, '1, "all warps stopped");
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic start_test();
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        $display("%s finished: %0d checks, %0d errors",
                 name, checks - checks_at_start, errors - errors_at_start);
    endtask

    task automatic test_iu_forms();
        start_test();
        start_program(2'd0, 8'hFF, 16'h0010);
        prog_op(EU_IU, IU_ADD,  8'd1,  8'd2,  8'd3,  2'b11);
        prog_op(EU_IU, IU_SUB,  8'd4,  8'd5,  8'd6,  2'b11);
        prog_op(EU_IU, IU_AND,  8'd7,  8'd8,  8'd9,  2'b11);
        prog_op(EU_IU, IU_OR,   8'd10, 8'd11, 8'd12, 2'b11);
        prog_op(EU_IU, IU_XOR,  8'd13, 8'd14, 8'd15, 2'b11);
        prog_op(EU_IU, IU_SHL,  8'd16, 8'd17, 8'd18, 2'b11);
        prog_op(EU_IU, IU_ADDI, 8'd19, 8'h05, 8'd20, 2'b10);
        prog_op(EU_IU, IU_SUBI, 8'd21, 8'h7F, 8'd22, 2'b10);
        prog_op(EU_IU, IU_SHLI, 8'd23, 8'h03, 8'd24, 2'b10);
        prog_stop();
        launch_warp(2'd0, 16'h0010, 8'hFF);
        wait_drained();
        check_streams();
        finish_test("iu forms");
    endtask

    task automatic test_lsu_branch();
        start_test();
        start_program(2'd1, 8'h0F, 16'h0020);
        prog_op(EU_LSU, 4'd0,       8'd5,  8'd6,  8'd7,  2'b11);
        prog_op(EU_BRU, BRU_BRANCH, 8'd0,  8'h03, 8'd2,  2'b10);
        // Fall-through after the branch
        prog_op(EU_IU,  IU_ADDI,    8'd8,  8'h11, 8'd9,  2'b10);
        prog_op(EU_LSU, 4'd1,       8'd0,  8'd3,  8'd4,  2'b11);
        prog_stop();
        launch_warp(2'd1, 16'h0020, 8'h0F);
        wait_drained();
        check_streams();
        finish_test("lsu and branch");
    endtask

    task automatic test_jumps();
        start_test();
        start_program(2'd1, 8'hF0, 16'h0040);
        prog_op(EU_IU, IU_ADD, 8'd1, 8'd2, 8'd3, 2'b11);
        prog_jump(16'sd5);
        prog_op(EU_IU, IU_SUB, 8'd4, 8'd5, 8'd6, 2'b11);
        prog_jump(-16'sd4);
        prog_op(EU_IU, IU_XOR, 8'd7, 8'd8, 8'd9, 2'b11);
        prog_jump(16'sd10);
        prog_stop();
        launch_warp(2'd1, 16'h0040, 8'hF0);
        wait_drained();
        check_streams();
        finish_test("jumps");
    endtask

    task automatic test_sync_stop();
        inst_t and_op;
        start_test();
        and_op.eu      = EU_IU;
        and_op.subtype = IU_AND;
        start_program(2'd2, 8'hA5, 16'h0060);
        prog_op(EU_IU, IU_ADD, 8'd1, 8'd2, 8'd3, 2'b11);
        prog_sync();
        prog_op(EU_IU, IU_OR, 8'd4, 8'd5, 8'd6, 2'b11);
        prog_stop();
        // Lies behind the stop and must never be dispatched
        prog_word(reg_word(and_op, 8'd7, 8'd8, 8'd9));
        launch_warp(2'd2, 16'h0060, 8'hA5);
        @(posedge clk_i);
        check_idle(warps_idle_o, ~(NUM_WARPS'(1) << 2), "warp 2 running");
        wait_drained();
        check_streams();
        finish_test("sync and stop");
    endtask

    task automatic test_two_warps();
        start_test();
        start_program(2'd0, 8'h3C, 16'h0080);
        prog_op(EU_IU, IU_ADD,  8'd1,  8'd2,  8'd3,  2'b11);
        prog_op(EU_IU, IU_XOR,  8'd4,  8'd5,  8'd6,  2'b11);
        prog_op(EU_IU, IU_SUBI, 8'd7,  8'h21, 8'd8,  2'b10);
        prog_op(EU_IU, IU_SHL,  8'd9,  8'd10, 8'd11, 2'b11);
        prog_op(EU_IU, IU_OR,   8'd12, 8'd13, 8'd14, 2'b11);
        prog_op(EU_IU, IU_ADDI, 8'd15, 8'h44, 8'd16, 2'b10);
        prog_stop();
        start_program(2'd3, 8'hC3, 16'h00A0);
        prog_op(EU_LSU, 4'd0,    8'd20, 8'd21, 8'd22, 2'b11);
        prog_op(EU_IU,  IU_SUB,  8'd23, 8'd24, 8'd25, 2'b11);
        prog_op(EU_LSU, 4'd1,    8'd0,  8'd26, 8'd27, 2'b11);
        prog_op(EU_IU,  IU_AND,  8'd28, 8'd29, 8'd30, 2'b11);
        prog_op(EU_IU,  IU_SHLI, 8'd31, 8'h02, 8'd32, 2'b10);
        prog_op(EU_IU,  IU_SUB,  8'd33, 8'd34, 8'd35, 2'b11);
        prog_stop();
        random_ready <= 1'b1;
        launch_warp(2'd0, 16'h0080, 8'h3C);
        launch_warp(2'd3, 16'h00A0, 8'hC3);
        wait_drained();
        random_ready <= 1'b0;
        check_streams();
        finish_test("two warps, random ready");
    endtask

    initial begin
        rst_n_i           = 1'b0;
        launch_i          = 1'b0;
        launch_warp_id_i  = '0;
        launch_pc_i       = '0;
        launch_act_mask_i = '0;
        prog_we_i         = 1'b0;
        prog_addr_i       = '0;
        prog_data_i       = '0;
        disp_ready_i      = 1'b0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        start_test();
        check_idle(warps_idle_o, '1, "idle after reset");
        checks++;
        if (disp_valid_o !== 1'b0) begin
            errors++;
            $display("error at %0t: disp_valid_o is high after reset", $time);
        end
        finish_test("reset state");
        test_iu_forms();
        test_lsu_branch();
        test_jumps();
        test_sync_stop();
        test_two_warps();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== bgpu_frontend.f ====
+incdir+include
logic/bgpu_isa_pkg.sv
logic/bgpu_pipe_pkg.sv
logic/warp_fetcher.sv
logic/inst_memory.sv
logic/decoder.sv
logic/dispatch_queue.sv
logic/bgpu_frontend.sv
tests/tb_bgpu_frontend.sv

// ==== Bender.yml ====
package:
  name: bgpu_frontend

sources:
  - include_dirs:
      - include
    files:
      - logic/bgpu_isa_pkg.sv
      - logic/bgpu_pipe_pkg.sv
      - logic/warp_fetcher.sv
      - logic/inst_memory.sv
      - logic/decoder.sv
      - logic/dispatch_queue.sv
      - logic/bgpu_frontend.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_bgpu_frontend.sv
